//--- pcie_dl_pkg.sv
// PCIe data link types
package pcie_dl_pkg;

  // InitFC opcodes, VC0
  typedef enum logic [7:0] {
    InitFC1_P   = 8'h40,
    InitFC1_NP  = 8'h50,
    InitFC1_Cpl = 8'h60,
    InitFC2_P   = 8'hC0,
    InitFC2_NP  = 8'hD0,
    InitFC2_Cpl = 8'hE0
  } dllp_type_e;

  // DLLP body, type byte is the first byte on the wire
  typedef struct packed {
    dllp_type_e  dllp_type;
    logic [1:0]  vc_id;
    logic [7:0]  hdr_fc;
    logic [1:0]  rsvd;
    logic [11:0] data_fc;
  } dllp_fc_t;

  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  keep;
    logic        last;
  } dllp_beat_t;

  typedef struct packed {
    logic [7:0]  hdr;
    logic [11:0] data;
  } fc_credits_t;

  typedef struct packed {
    fc_credits_t p;
    fc_credits_t np;
    fc_credits_t cpl;
  } fc_limits_t;

  typedef enum logic [1:0] {PH_IDLE, PH_FC1, PH_FC2, PH_DONE} fc_phase_e;

  typedef enum logic [1:0] {CL_P, CL_NP, CL_CPL} fc_class_e;

  localparam logic [7:0]  HDR_MIN_CREDITS = 8'd64;
  localparam logic [15:0] CRC_INIT = 16'hFFFF;

  // wire order of the crc, each byte bit-reversed
  function automatic logic [15:0] crc_bitrev(input logic [15:0] crc);
    logic [15:0] rev;
    for (int i = 0; i < 8; i++) begin
      rev[i]     = crc[7 - i];
      rev[i + 8] = crc[15 - i];
    end
    return rev;
  endfunction

endpackage

//--- pcie_dllp_crc.sv
// DLLP CRC-16 generator
`timescale 1ns/1ps

module pcie_dllp_crc (
  input  logic [31:0] data_i,
  output logic [15:0] crc_o
);

  localparam logic [15:0] POLY = 16'h100B;

  // byte 0 sits in data_i[31:24], each byte shifted in lsb first
  always_comb begin : crc_calc
    logic [15:0] crc;
    logic [7:0]  byte_v;
    logic        fb;
    crc = pcie_dl_pkg::CRC_INIT;
    for (int b = 0; b < 4; b++) begin
      byte_v = data_i[31 - 8 * b -: 8];
      for (int i = 0; i < 8; i++) begin
        fb  = crc[15] ^ byte_v[i];
        crc = {crc[14:0], 1'b0} ^ (fb ? POLY : 16'h0000);
      end
    end
    crc_o = crc;
  end

endmodule

//--- pcie_dllp_skid.sv
// DLLP stream skid buffer
`timescale 1ns/1ps

module pcie_dllp_skid (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  pcie_dl_pkg::dllp_beat_t s_beat_i,
  input  logic                   s_valid_i,
  output logic                   s_ready_o,
  output pcie_dl_pkg::dllp_beat_t m_beat_o,
  output logic                   m_valid_o,
  input  logic                   m_ready_i
);

  pcie_dl_pkg::dllp_beat_t skid_beat_q;
  logic                    skid_valid_q;
  logic                    m_valid_q;
  logic                    s_fire;
  logic                    load_main;
  logic                    load_skid;

  // ready only looks at the skid slot
  assign s_ready_o = ~skid_valid_q;
  assign m_valid_o = m_valid_q;
  assign s_fire    = s_valid_i & s_ready_o;
  assign load_main = skid_valid_q ? m_ready_i : (s_fire & (~m_valid_q | m_ready_i));
  assign load_skid = s_fire & m_valid_q & ~m_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      m_valid_q    <= 1'b0;
      skid_valid_q <= 1'b0;
    end else begin
      if (load_main) begin
        m_valid_q <= 1'b1;
      end else if (m_ready_i) begin
        m_valid_q <= 1'b0;
      end
      if (load_skid) begin
        skid_valid_q <= 1'b1;
      end else if (m_ready_i) begin
        skid_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_main) begin
      m_beat_o <= skid_valid_q ? skid_beat_q : s_beat_i;
    end
    if (load_skid) begin
      skid_beat_q <= s_beat_i;
    end
  end

  // stalled beat is held
  assert property (@(posedge clk_i) disable iff (rst_i)
    m_valid_o && !m_ready_i |=> m_valid_o && $stable(m_beat_o));

endmodule

//--- pcie_fc_init_tx.sv
// InitFC transmit sequencer
`timescale 1ns/1ps

module pcie_fc_init_tx #(
  parameter int FC_WAIT_CYCLES   = 160,
  parameter int MAX_PAYLOAD_CODE = 1
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    start_i,
  input  logic                    fc1_stored_i,
  input  logic                    fc2_stored_i,
  output pcie_dl_pkg::dllp_beat_t  beat_o,
  output logic                    valid_o,
  input  logic                    ready_i,
  output logic                    init_ack_o,
  output pcie_dl_pkg::fc_phase_e   phase_o
);

  localparam int TW = $clog2(FC_WAIT_CYCLES + 1);
  // one data credit per 16 bytes of max payload
  localparam logic [11:0] P_DATA_CREDITS = 12'((128 << MAX_PAYLOAD_CODE) / 16);

  typedef enum logic [2:0] {
    ST_IDLE, ST_BODY, ST_CRC, ST_GAP, ST_CHECK, ST_DONE
  } tx_state_e;

  tx_state_e               state_q, state_d;
  pcie_dl_pkg::fc_class_e  cls_q, cls_d;
  logic                    fc2_q, fc2_d;
  logic [TW-1:0]           timer_q, timer_d;
  logic                    timer_hit;
  logic                    init_ack_q;
  pcie_dl_pkg::dllp_fc_t   body;
  logic [15:0]             crc_calc;
  logic [15:0]             crc_q;

  assign timer_hit  = (timer_q == TW'(FC_WAIT_CYCLES - 1));
  assign init_ack_o = init_ack_q;

  always_comb begin
    body        = '0;
    body.vc_id  = 2'd0;
    case (cls_q)
      pcie_dl_pkg::CL_P: begin
        body.dllp_type = fc2_q ? pcie_dl_pkg::InitFC2_P : pcie_dl_pkg::InitFC1_P;
        body.hdr_fc    = pcie_dl_pkg::HDR_MIN_CREDITS;
        body.data_fc   = P_DATA_CREDITS;
      end
      pcie_dl_pkg::CL_NP: begin
        body.dllp_type = fc2_q ? pcie_dl_pkg::InitFC2_NP : pcie_dl_pkg::InitFC1_NP;
        body.hdr_fc    = pcie_dl_pkg::HDR_MIN_CREDITS;
        body.data_fc   = 12'(pcie_dl_pkg::HDR_MIN_CREDITS);
      end
      default: begin
        // zero credits advertise infinite completions
        body.dllp_type = fc2_q ? pcie_dl_pkg::InitFC2_Cpl : pcie_dl_pkg::InitFC1_Cpl;
      end
    endcase
  end

  pcie_dllp_crc u_crc (
    .data_i(body),
    .crc_o (crc_calc)
  );

  always_comb begin
    state_d = state_q;
    cls_d   = cls_q;
    fc2_d   = fc2_q;
    timer_d = timer_q + 1'b1;
    case (state_q)
      ST_IDLE: begin
        timer_d = '0;
        if (start_i) begin
          state_d = ST_BODY;
          cls_d   = pcie_dl_pkg::CL_P;
          fc2_d   = 1'b0;
        end
      end
      ST_BODY: begin
        if (ready_i) state_d = ST_CRC;
      end
      ST_CRC: begin
        if (ready_i) begin
          timer_d = '0;
          case (cls_q)
            pcie_dl_pkg::CL_P: begin
              cls_d   = pcie_dl_pkg::CL_NP;
              state_d = ST_GAP;
            end
            pcie_dl_pkg::CL_NP: begin
              cls_d   = pcie_dl_pkg::CL_CPL;
              state_d = ST_GAP;
            end
            default: state_d = ST_CHECK;
          endcase
        end
      end
      ST_GAP: begin
        if (timer_hit) state_d = ST_BODY;
      end
      ST_CHECK: begin
        if (fc2_q ? fc2_stored_i : fc1_stored_i) begin
          state_d = fc2_q ? ST_DONE : ST_BODY;
          cls_d   = pcie_dl_pkg::CL_P;
          fc2_d   = 1'b1;
        end else if (timer_hit) begin
          // FC1 timeout restarts from idle, FC2 timeout resends the set
          state_d = fc2_q ? ST_BODY : ST_IDLE;
          cls_d   = pcie_dl_pkg::CL_P;
        end
      end
      default: begin
        timer_d = '0;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q    <= ST_IDLE;
      cls_q      <= pcie_dl_pkg::CL_P;
      fc2_q      <= 1'b0;
      timer_q    <= '0;
      init_ack_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      cls_q      <= cls_d;
      fc2_q      <= fc2_d;
      timer_q    <= timer_d;
      init_ack_q <= (state_q == ST_IDLE) && start_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == ST_BODY) crc_q <= crc_calc;
  end

  always_comb begin
    beat_o  = '0;
    valid_o = 1'b0;
    if (state_q == ST_BODY) begin
      beat_o.data = body;
      beat_o.keep = 4'hF;
      valid_o     = 1'b1;
    end else if (state_q == ST_CRC) begin
      beat_o.data = {16'h0000, pcie_dl_pkg::crc_bitrev(crc_q)};
      beat_o.keep = 4'h3;
      beat_o.last = 1'b1;
      valid_o     = 1'b1;
    end
  end

  always_comb begin
    case (state_q)
      ST_IDLE: phase_o = pcie_dl_pkg::PH_IDLE;
      ST_DONE: phase_o = pcie_dl_pkg::PH_DONE;
      default: phase_o = fc2_q ? pcie_dl_pkg::PH_FC2 : pcie_dl_pkg::PH_FC1;
    endcase
  end

  assert property (@(posedge clk_i) disable iff (rst_i)
    state_q inside {ST_IDLE, ST_BODY, ST_CRC, ST_GAP, ST_CHECK, ST_DONE});

endmodule

//--- pcie_fc_rx_tracker.sv
// InitFC receive tracker
`timescale 1ns/1ps

module pcie_fc_rx_tracker (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  pcie_dl_pkg::dllp_beat_t  beat_i,
  input  logic                    valid_i,
  output logic                    ready_o,
  output logic [5:0]              seen_o,
  output pcie_dl_pkg::fc_limits_t  credits_o
);

  pcie_dl_pkg::dllp_fc_t     body_q;
  logic                      body_valid_q;
  logic [15:0]               crc_calc;
  logic                      crc_ok;
  logic                      dllp_ok;
  logic [5:0]                hit_mask;
  logic                      is_fc1;
  pcie_dl_pkg::fc_class_e    cls;
  pcie_dl_pkg::fc_credits_t  rx_cr;

  // bad DLLPs are dropped, never stalled
  assign ready_o = 1'b1;

  pcie_dllp_crc u_crc (
    .data_i(body_q),
    .crc_o (crc_calc)
  );

  assign crc_ok  = (pcie_dl_pkg::crc_bitrev(crc_calc) == beat_i.data[15:0]);
  assign dllp_ok = valid_i && beat_i.last && body_valid_q && crc_ok;
  assign rx_cr   = '{hdr: body_q.hdr_fc, data: body_q.data_fc};

  always_comb begin
    hit_mask = '0;
    is_fc1   = 1'b0;
    cls      = pcie_dl_pkg::CL_P;
    case (body_q.dllp_type)
      pcie_dl_pkg::InitFC1_P: begin
        hit_mask = 6'b000001;
        is_fc1   = 1'b1;
      end
      pcie_dl_pkg::InitFC1_NP: begin
        hit_mask = 6'b000010;
        is_fc1   = 1'b1;
        cls      = pcie_dl_pkg::CL_NP;
      end
      pcie_dl_pkg::InitFC1_Cpl: begin
        hit_mask = 6'b000100;
        is_fc1   = 1'b1;
        cls      = pcie_dl_pkg::CL_CPL;
      end
      pcie_dl_pkg::InitFC2_P:   hit_mask = 6'b001000;
      pcie_dl_pkg::InitFC2_NP:  hit_mask = 6'b010000;
      pcie_dl_pkg::InitFC2_Cpl: hit_mask = 6'b100000;
      default:                  hit_mask = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      body_valid_q <= 1'b0;
      seen_o       <= '0;
      credits_o    <= '0;
    end else begin
      seen_o <= dllp_ok ? hit_mask : 6'b000000;
      if (valid_i) begin
        // a stray crc beat drops whatever body was pending
        body_valid_q <= !beat_i.last && (beat_i.keep == 4'hF);
      end
      if (dllp_ok && is_fc1) begin
        case (cls)
          pcie_dl_pkg::CL_P:  credits_o.p  <= rx_cr;
          pcie_dl_pkg::CL_NP: credits_o.np <= rx_cr;
          default:            credits_o.cpl <= rx_cr;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && !beat_i.last) body_q <= pcie_dl_pkg::dllp_fc_t'(beat_i.data);
  end

endmodule

//--- pcie_fc_link_ctrl.sv
// flow control link status
`timescale 1ns/1ps

module pcie_fc_link_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  pcie_dl_pkg::fc_phase_e   phase_i,
  input  logic [5:0]              seen_i,
  input  pcie_dl_pkg::fc_limits_t  credits_i,
  output logic                    fc1_stored_o,
  output logic                    fc2_stored_o,
  output logic                    dl_up_o,
  output pcie_dl_pkg::fc_limits_t  limits_o
);

  logic [5:0] hist_q, hist_d;
  logic       fc1_d;
  logic       fc2_d;

  // bits 2:0 are InitFC1 P/NP/Cpl, bits 5:3 the InitFC2 set
  always_comb begin
    hist_d = hist_q | seen_i;
    fc1_d  = (&hist_d[2:0]) | (|hist_d[5:3]);
    fc2_d  = fc2_stored_o | ((phase_i == pcie_dl_pkg::PH_FC2) && (|seen_i[5:3]));
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      hist_q       <= '0;
      fc1_stored_o <= 1'b0;
      fc2_stored_o <= 1'b0;
      dl_up_o      <= 1'b0;
      limits_o     <= '0;
    end else begin
      if (phase_i == pcie_dl_pkg::PH_IDLE) begin
        hist_q       <= '0;
        fc1_stored_o <= 1'b0;
        fc2_stored_o <= 1'b0;
      end else begin
        hist_q       <= hist_d;
        fc1_stored_o <= fc1_d;
        fc2_stored_o <= fc2_d;
        // partner limits taken on the rising edge of fc1
        if (fc1_d && !fc1_stored_o) limits_o <= credits_i;
      end
      if (phase_i == pcie_dl_pkg::PH_DONE) dl_up_o <= 1'b1;
    end
  end

  assert property (@(posedge clk_i) disable iff (rst_i) dl_up_o |-> fc2_stored_o);

endmodule

//--- pcie_fc_init_top.sv
// flow control init subsystem
`timescale 1ns/1ps

module pcie_fc_init_top #(
  parameter int FC_WAIT_CYCLES   = 160,
  parameter int MAX_PAYLOAD_CODE = 1
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    start_i,
  input  pcie_dl_pkg::dllp_beat_t  rx_beat_i,
  input  logic                    rx_valid_i,
  output logic                    rx_ready_o,
  output pcie_dl_pkg::dllp_beat_t  tx_beat_o,
  output logic                    tx_valid_o,
  input  logic                    tx_ready_i,
  output logic                    init_ack_o,
  output logic                    dl_up_o,
  output pcie_dl_pkg::fc_limits_t  fc_limits_o
);

  pcie_dl_pkg::dllp_beat_t  seq_beat;
  logic                     seq_valid;
  logic                     seq_ready;
  logic                     fc1_stored;
  logic                     fc2_stored;
  pcie_dl_pkg::fc_phase_e   phase;
  logic [5:0]               rx_seen;
  pcie_dl_pkg::fc_limits_t  rx_credits;

  pcie_fc_init_tx #(
    .FC_WAIT_CYCLES  (FC_WAIT_CYCLES),
    .MAX_PAYLOAD_CODE(MAX_PAYLOAD_CODE)
  ) u_tx (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .start_i     (start_i),
    .fc1_stored_i(fc1_stored),
    .fc2_stored_i(fc2_stored),
    .beat_o      (seq_beat),
    .valid_o     (seq_valid),
    .ready_i     (seq_ready),
    .init_ack_o  (init_ack_o),
    .phase_o     (phase)
  );

  pcie_dllp_skid u_skid (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .s_beat_i (seq_beat),
    .s_valid_i(seq_valid),
    .s_ready_o(seq_ready),
    .m_beat_o (tx_beat_o),
    .m_valid_o(tx_valid_o),
    .m_ready_i(tx_ready_i)
  );

  pcie_fc_rx_tracker u_rx (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .beat_i   (rx_beat_i),
    .valid_i  (rx_valid_i),
    .ready_o  (rx_ready_o),
    .seen_o   (rx_seen),
    .credits_o(rx_credits)
  );

  pcie_fc_link_ctrl u_link (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .phase_i     (phase),
    .seen_i      (rx_seen),
    .credits_i   (rx_credits),
    .fc1_stored_o(fc1_stored),
    .fc2_stored_o(fc2_stored),
    .dl_up_o     (dl_up_o),
    .limits_o    (fc_limits_o)
  );

endmodule

//--- tb_fc_ref.svh
// InitFC reference model
`ifndef TB_FC_REF_SVH
`define TB_FC_REF_SVH

// posted data credits for a max payload code, in 16-byte units
function automatic logic [11:0] mps_data_credits(input int code);
  case (code)
    0:       return 12'd8;
    1:       return 12'd16;
    2:       return 12'd32;
    3:       return 12'd64;
    4:       return 12'd128;
    default: return 12'd256;
  endcase
endfunction

// body of the DLLP the sequencer should send for one class
function automatic pcie_dl_pkg::dllp_fc_t ref_body(input bit fc2,
                                                   input pcie_dl_pkg::fc_class_e cls);
  pcie_dl_pkg::dllp_fc_t b;
  b = '0;
  case (cls)
    pcie_dl_pkg::CL_P: begin
      b.dllp_type = fc2 ? pcie_dl_pkg::InitFC2_P : pcie_dl_pkg::InitFC1_P;
      b.hdr_fc    = 8'd64;
      b.data_fc   = mps_data_credits(MPS_CODE);
    end
    pcie_dl_pkg::CL_NP: begin
      b.dllp_type = fc2 ? pcie_dl_pkg::InitFC2_NP : pcie_dl_pkg::InitFC1_NP;
      b.hdr_fc    = 8'd64;
      b.data_fc   = 12'd64;
    end
    default: begin
      // infinite completion credits
      b.dllp_type = fc2 ? pcie_dl_pkg::InitFC2_Cpl : pcie_dl_pkg::InitFC1_Cpl;
    end
  endcase
  return b;
endfunction

// CRC-16 with byte 0 first and each byte lsb first
function automatic logic [15:0] ref_crc(input logic [31:0] body);
  logic [15:0] crc;
  logic        in_bit;
  logic        msb;
  crc = 16'hFFFF;
  for (int k = 0; k < 32; k++) begin
    in_bit = body[24 - 8 * (k / 8) + (k % 8)];
    msb    = crc[15] ^ in_bit;
    crc    = crc << 1;
    if (msb) crc = crc ^ 16'h100B;
  end
  return crc;
endfunction

function automatic logic [15:0] ref_wire_crc(input logic [15:0] crc);
  logic [15:0] w;
  for (int i = 0; i < 16; i++) begin
    w[i] = crc[(i / 8) * 8 + 7 - (i % 8)];
  end
  return w;
endfunction

function automatic pcie_dl_pkg::dllp_beat_t body_beat(input pcie_dl_pkg::dllp_fc_t body);
  pcie_dl_pkg::dllp_beat_t b;
  b.data = body;
  b.keep = 4'hF;
  b.last = 1'b0;
  return b;
endfunction

function automatic pcie_dl_pkg::dllp_beat_t crc_beat(input pcie_dl_pkg::dllp_fc_t body);
  pcie_dl_pkg::dllp_beat_t b;
  b.data = {16'h0000, ref_wire_crc(ref_crc(body))};
  b.keep = 4'h3;
  b.last = 1'b1;
  return b;
endfunction

task automatic check_beat(input string what, input pcie_dl_pkg::dllp_beat_t got,
                          input pcie_dl_pkg::dllp_beat_t exp);
  if (got !== exp) begin
    stop_on_error($sformatf("ERR %0t: %s beat %h/%h/%b, expected %h/%h/%b", $time, what,
                            got.data, got.keep, got.last, exp.data, exp.keep, exp.last));
  end
endtask

task automatic check_limits(input pcie_dl_pkg::fc_limits_t got,
                            input pcie_dl_pkg::fc_limits_t exp);
  if (got !== exp) begin
    stop_on_error($sformatf("ERR %0t: fc_limits_o %h, expected %h", $time, got, exp));
  end
endtask

`endif

//--- tb_fc_init.sv
// InitFC subsystem testbench
`timescale 1ns/1ps

module tb_fc_init;

  localparam int FC_WAIT  = 16;
  localparam int MPS_CODE = 1;

  logic                    clk_i;
  logic                    rst_i;
  logic                    start_i;
  pcie_dl_pkg::dllp_beat_t rx_beat_i;
  logic                    rx_valid_i;
  logic                    rx_ready_o;
  pcie_dl_pkg::dllp_beat_t tx_beat_o;
  logic                    tx_valid_o;
  logic                    tx_ready_i;
  logic                    init_ack_o;
  logic                    dl_up_o;
  pcie_dl_pkg::fc_limits_t fc_limits_o;

  int seed = 0;
  int bad_idx;
  logic stall_en = 1'b0;
  logic partner_fc1_done = 1'b0;
  int dllp_count = 0;
  int ack_count = 0;
  int fc2_dllps = 0;
  logic fc2_started = 1'b0;

  // checker state
  logic in_crc;
  int cls_idx;
  logic set_fc2;
  logic prev_stall;
  logic ack_prev;
  logic dl_up_seen;
  pcie_dl_pkg::dllp_fc_t cur_body;
  pcie_dl_pkg::dllp_beat_t prev_beat;
  pcie_dl_pkg::dllp_fc_t good_body;
  pcie_dl_pkg::dllp_fc_t bad_body;
  pcie_dl_pkg::fc_limits_t exp_limits;

  pcie_fc_init_top #(
    .FC_WAIT_CYCLES  (FC_WAIT),
    .MAX_PAYLOAD_CODE(MPS_CODE)
  ) UUT (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .start_i    (start_i),
    .rx_beat_i  (rx_beat_i),
    .rx_valid_i (rx_valid_i),
    .rx_ready_o (rx_ready_o),
    .tx_beat_o  (tx_beat_o),
    .tx_valid_o (tx_valid_o),
    .tx_ready_i (tx_ready_i),
    .init_ack_o (init_ack_o),
    .dl_up_o    (dl_up_o),
    .fc_limits_o(fc_limits_o)
  );

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("Errors found");
    $fatal(1);
  endtask

  `include "tb_fc_ref.svh"

  // credits the link partner advertises
  function automatic pcie_dl_pkg::fc_credits_t partner_credits(input pcie_dl_pkg::fc_class_e c);
    case (c)
      pcie_dl_pkg::CL_P:  return '{hdr: 8'd32, data: 12'd128};
      pcie_dl_pkg::CL_NP: return '{hdr: 8'd16, data: 12'd8};
      default:            return '{hdr: 8'd4, data: 12'd40};
    endcase
  endfunction

  function automatic pcie_dl_pkg::dllp_fc_t partner_body(input bit fc2,
                                                         input pcie_dl_pkg::fc_class_e c);
    pcie_dl_pkg::dllp_fc_t    b;
    pcie_dl_pkg::fc_credits_t cr;
    b         = ref_body(fc2, c);
    cr        = partner_credits(c);
    b.hdr_fc  = cr.hdr;
    b.data_fc = cr.data;
    return b;
  endfunction

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    if (stall_en) begin
      tx_ready_i <= (($random(seed) & 3) != 0);
    end else begin
      tx_ready_i <= 1'b1;
    end
  end

  task automatic send_beat(input pcie_dl_pkg::dllp_beat_t b);
    int cycles;
    cycles = 0;
    rx_beat_i  <= b;
    rx_valid_i <= 1'b1;
    @(posedge clk_i);
    while (!rx_ready_o) begin
      cycles++;
      if (cycles > 100) stop_on_error("timeout waiting for rx_ready_o");
      @(posedge clk_i);
    end
  endtask

  task automatic send_dllp(input pcie_dl_pkg::dllp_fc_t body, input bit corrupt);
    pcie_dl_pkg::dllp_beat_t c;
    c = crc_beat(body);
    if (corrupt) c.data[8] = ~c.data[8];
    send_beat(body_beat(body));
    send_beat(c);
  endtask

  task automatic wait_dllps(input int n, input int limit);
    int cycles;
    cycles = 0;
    while (dllp_count < n) begin
      @(posedge clk_i);
      cycles++;
      if (cycles > limit) stop_on_error($sformatf("timeout waiting for %0d DLLPs", n));
    end
  endtask

  task automatic wait_ack(input int limit);
    int cycles;
    cycles = 0;
    while (ack_count < 1) begin
      @(posedge clk_i);
      cycles++;
      if (cycles > limit) stop_on_error("timeout waiting for init_ack_o");
    end
  endtask

  task automatic wait_fc2_start(input int limit);
    int cycles;
    cycles = 0;
    while (!fc2_started) begin
      @(posedge clk_i);
      cycles++;
      if (cycles > limit) stop_on_error("timeout waiting for the InitFC2 set");
    end
  endtask

  task automatic wait_link_up(input int limit);
    int cycles;
    cycles = 0;
    while (!dl_up_o) begin
      @(posedge clk_i);
      cycles++;
      if (cycles > limit) stop_on_error("timeout waiting for dl_up_o");
    end
  endtask

  // compares every transmitted beat with the reference sequence
  always @(posedge clk_i) begin
    if (rst_i) begin
      in_crc     = 1'b0;
      cls_idx    = 0;
      set_fc2    = 1'b0;
      prev_stall = 1'b0;
      ack_prev   = 1'b0;
      dl_up_seen = 1'b0;
    end else begin
      if (prev_stall && (!tx_valid_o || tx_beat_o !== prev_beat)) begin
        stop_on_error($sformatf("ERR %0t: tx beat changed while stalled", $time));
      end
      prev_stall = tx_valid_o && !tx_ready_i;
      prev_beat  = tx_beat_o;
      if (init_ack_o) begin
        if (ack_prev) stop_on_error($sformatf("ERR %0t: init_ack_o longer than a cycle", $time));
        ack_count <= ack_count + 1;
      end
      ack_prev = init_ack_o;
      if (tx_valid_o && tx_ready_i) begin
        if (!in_crc) begin
          // the set type is fixed by its first DLLP
          if (cls_idx == 0) set_fc2 = partner_fc1_done;
          cur_body = ref_body(set_fc2, pcie_dl_pkg::fc_class_e'(cls_idx));
          check_beat("body", tx_beat_o, body_beat(cur_body));
          if (set_fc2 && cls_idx == 0) fc2_started <= 1'b1;
          in_crc = 1'b1;
        end else begin
          check_beat("crc", tx_beat_o, crc_beat(cur_body));
          if (set_fc2) fc2_dllps <= fc2_dllps + 1;
          dllp_count <= dllp_count + 1;
          cls_idx = (cls_idx + 1) % 3;
          in_crc  = 1'b0;
        end
      end
      if (dl_up_o) begin
        dl_up_seen = 1'b1;
        if (tx_valid_o) stop_on_error($sformatf("ERR %0t: transmit after link up", $time));
      end else if (dl_up_seen) begin
        stop_on_error($sformatf("ERR %0t: dl_up_o dropped", $time));
      end
    end
  end

  initial begin
    seed       = 32'h311e;
    rst_i      = 1'b1;
    start_i    = 1'b0;
    rx_beat_i  = '0;
    rx_valid_i = 1'b0;
    tx_ready_i = 1'b1;
    bad_idx    = $unsigned($random(seed)) % 3;
    repeat (5) @(posedge clk_i);
    rst_i <= 1'b0;
    repeat (10) begin
      @(posedge clk_i);
      if (tx_valid_o !== 1'b0 || init_ack_o !== 1'b0 || dl_up_o !== 1'b0 ||
          rx_ready_o !== 1'b1) begin
        stop_on_error($sformatf("ERR %0t: outputs not idle before start", $time));
      end
    end
    start_i <= 1'b1;
    wait_ack(10);
    wait_dllps(3, 200);
    stall_en <= 1'b1;
    // silent partner makes the FC1 set repeat from idle
    wait_dllps(7, 1000);
    if (ack_count != 3) begin
      stop_on_error($sformatf("ERR %0t: %0d init_ack_o pulses, expected 3", $time, ack_count));
    end
    for (int i = 0; i < 3; i++) begin
      if (i != bad_idx) begin
        send_dllp(partner_body(1'b0, pcie_dl_pkg::fc_class_e'(i)), 1'b0);
      end
    end
    // the corrupted copy would complete the FC1 set if its CRC were ignored
    good_body        = partner_body(1'b0, pcie_dl_pkg::fc_class_e'(bad_idx));
    bad_body         = good_body;
    bad_body.hdr_fc  = good_body.hdr_fc + 8'd1;
    bad_body.data_fc = good_body.data_fc + 12'd1;
    send_dllp(bad_body, 1'b1);
    send_dllp(good_body, 1'b0);
    rx_valid_i       <= 1'b0;
    partner_fc1_done <= 1'b1;
    wait_fc2_start(600);
    exp_limits.p   = partner_credits(pcie_dl_pkg::CL_P);
    exp_limits.np  = partner_credits(pcie_dl_pkg::CL_NP);
    exp_limits.cpl = partner_credits(pcie_dl_pkg::CL_CPL);
    check_limits(fc_limits_o, exp_limits);
    for (int i = 0; i < 3; i++) begin
      send_dllp(partner_body(1'b1, pcie_dl_pkg::fc_class_e'(i)), 1'b0);
    end
    rx_valid_i <= 1'b0;
    wait_link_up(600);
    repeat (5 * FC_WAIT) @(posedge clk_i);
    check_limits(fc_limits_o, exp_limits);
    if (fc2_dllps != 3) begin
      stop_on_error($sformatf("ERR %0t: %0d InitFC2 DLLPs sent, expected 3", $time, fc2_dllps));
    end else begin
      $display("No errors");
      $finish;
    end
  end

endmodule

//--- files.f
+incdir+.
pcie_dl_pkg.sv
pcie_dllp_crc.sv
pcie_dllp_skid.sv
pcie_fc_init_tx.sv
pcie_fc_rx_tracker.sv
pcie_fc_link_ctrl.sv
pcie_fc_init_top.sv
tb_fc_init.sv

//--- Bender.yml
package:
  name: pcie_fc_init

sources:
  - pcie_dl_pkg.sv
  - pcie_dllp_crc.sv
  - pcie_dllp_skid.sv
  - pcie_fc_init_tx.sv
  - pcie_fc_rx_tracker.sv
  - pcie_fc_link_ctrl.sv
  - pcie_fc_init_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_fc_init.sv
